//--- verilog/rpPkg.sv
// Disk controller shared definitions
// Register addresses, function codes, status and error bit positions

`default_nettype none

package rpPkg;

   ////////////////////////////////////////////////////////////
   // Register addresses
   ////////////////////////////////////////////////////////////

   localparam logic [2:0] RP_ADDR_CS1 = 3'd0;
   localparam logic [2:0] RP_ADDR_DS  = 3'd1;
   localparam logic [2:0] RP_ADDR_ER1 = 3'd2;
   localparam logic [2:0] RP_ADDR_DA  = 3'd3;
   localparam logic [2:0] RP_ADDR_AS  = 3'd4;

   ////////////////////////////////////////////////////////////
   // Function codes, CS1 bits 5 to 1
   ////////////////////////////////////////////////////////////

   localparam logic [4:0] FN_NOP    = 5'o00;
   localparam logic [4:0] FN_SEEK   = 5'o02;
   localparam logic [4:0] FN_DRVCLR = 5'o04;
   localparam logic [4:0] FN_PRESET = 5'o10;
   localparam logic [4:0] FN_PAKACK = 5'o11;
   localparam logic [4:0] FN_READ   = 5'o34;

   // Drive status word bits
   localparam int DS_ATA = 15;
   localparam int DS_ERR = 14;
   localparam int DS_PIP = 13;
   localparam int DS_MOL = 12;
   localparam int DS_WRL = 11;
   localparam int DS_LST = 10;
   localparam int DS_PGM = 9;
   localparam int DS_DPR = 8;
   localparam int DS_DRY = 7;
   localparam int DS_VV  = 6;

   // Error register 1 bits
   localparam int ER1_ILF = 0;
   localparam int ER1_RMR = 2;
   localparam int ER1_UNS = 14;

   // Highest sector number on a track
   localparam logic [7:0] RP_LAST_SECTOR = 8'd21;

   // Control view of a host word
   typedef struct packed {
      logic [9:0] rsvd;
      logic [4:0] fn;
      logic       go;
   } rpCsWord_t;

   // Disk address view of a host word
   typedef struct packed {
      logic [7:0] track;
      logic [7:0] sector;
   } rpDaWord_t;

   // Same 16 bits, meaning set by the register address
   typedef union packed {
      rpCsWord_t cs;
      rpDaWord_t da;
   } rpWriteWord_t;

   // Per drive command, pulses plus the sticky function field
   typedef struct packed {
      logic        go;
      logic        seek;
      logic        read;
      logic        drvClr;
      logic        preset;
      logic        pakAck;
      logic        illegal;
      logic        daWrite;
      logic [15:0] daValue;
      logic [4:0]  lastFn;
   } rpCmd_t;

endpackage

`default_nettype wire

//--- verilog/rpCmdDecode.sv
// Host write decoder
// Turns register writes into registered per-drive command pulses

`default_nettype none

module rpCmdDecode #(
   parameter int NUM_DRIVES = 4
)
(
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 regWrite,
   input  logic [2:0]                           regAddr,
   input  logic [1:0]                           drvSel,
   input  rpPkg::rpWriteWord_t                  wrData,
   output rpPkg::rpCmd_t [NUM_DRIVES-1:0]       cmd,
   output logic [NUM_DRIVES-1:0]                ataClr
);

   rpPkg::rpCmd_t [NUM_DRIVES-1:0] cmdNext;
   logic [NUM_DRIVES-1:0]          ataClrNext;

   ////////////////////////////////////////////////////////////
   // Next command per drive
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      ataClrNext = '0;
      for (int i = 0; i < NUM_DRIVES; i++)
      begin
         // Pulses default low
         cmdNext[i] = '0;
         // Function field held for CS1 readback
         cmdNext[i].lastFn = cmd[i].lastFn;
         if (regWrite && (int'(drvSel) == i))
         begin
            case (regAddr)
               rpPkg::RP_ADDR_CS1:
               begin
                  // Control view of the write word
                  cmdNext[i].lastFn = wrData.cs.fn;
                  if (wrData.cs.go)
                  begin
                     cmdNext[i].go = 1'b1;
                     case (wrData.cs.fn)
                        // NOP only raises GO
                        rpPkg::FN_NOP:    ;
                        rpPkg::FN_SEEK:   cmdNext[i].seek    = 1'b1;
                        rpPkg::FN_DRVCLR: cmdNext[i].drvClr  = 1'b1;
                        rpPkg::FN_PRESET: cmdNext[i].preset  = 1'b1;
                        rpPkg::FN_PAKACK: cmdNext[i].pakAck  = 1'b1;
                        rpPkg::FN_READ:   cmdNext[i].read    = 1'b1;
                        default:          cmdNext[i].illegal = 1'b1;
                     endcase
                  end
               end
               rpPkg::RP_ADDR_DA:
               begin
                  // Address view of the same word
                  cmdNext[i].daWrite = 1'b1;
                  cmdNext[i].daValue = {wrData.da.track, wrData.da.sector};
               end
               // DS, ER1 and AS have no per-drive write side
               default: ;
            endcase
         end
      end
      // AS write is common to all drives, ones clear ATA
      if (regWrite && (regAddr == rpPkg::RP_ADDR_AS))
      begin
         ataClrNext = wrData[NUM_DRIVES-1:0];
      end
   end

   // Output registers
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cmd    <= '0;
         ataClr <= '0;
      end
      else
      begin
         cmd    <= cmdNext;
         ataClr <= ataClrNext;
      end
   end

endmodule

`default_nettype wire

//--- verilog/rpDrive.sv
// Single disk drive
// Status word, error register 1, disk address and seek or read busy timer

`default_nettype none

module rpDrive #(
   parameter int SEEK_TIME = 12,
   parameter int XFER_TIME = 6
)
(
   input  logic          clk,
   input  logic          rst,
   input  logic          clr,
   input  rpPkg::rpCmd_t cmd,
   input  logic          ataClr,
   input  logic          mol,
   input  logic          wrl,
   input  logic          dpr,
   output logic [15:0]   ds,
   output logic [15:0]   er1,
   output logic [15:0]   da,
   output logic          busyDone
);

   // Timer wide enough for the longer operation
   localparam int CNT_MAX = (SEEK_TIME > XFER_TIME) ? SEEK_TIME : XFER_TIME;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   logic [CNT_W-1:0]  busyCnt;
   logic              opSeek;
   logic              busy;
   logic              lastMol;
   logic              molChg;
   logic              molRise;
   logic              ataReg;
   logic              lstReg;
   logic              vvReg;
   logic [15:0]       er1Reg;
   rpPkg::rpDaWord_t  daReg;
   logic              err;
   logic              refuseIlf;
   logic              refuseRmr;
   logic              refuseUns;
   logic              accept;
   logic              ataSet;
   logic              readDone;

   assign busy = (busyCnt != '0);
   // Composite error, ER1 only
   assign err  = |er1Reg;

   ////////////////////////////////////////////////////////////
   // Command qualification
   ////////////////////////////////////////////////////////////

   assign refuseIlf = cmd.go & cmd.illegal;
   // Any command to a busy drive is refused
   assign refuseRmr = cmd.go & ~cmd.illegal & busy;
   // Motion needs media on-line
   assign refuseUns = cmd.go & ~cmd.illegal & ~busy & (cmd.seek | cmd.read) & ~mol;
   assign accept    = cmd.go & ~refuseIlf & ~refuseRmr & ~refuseUns;

   // Last count cycle, unless clr aborts it
   assign busyDone  = (busyCnt == CNT_W'(1)) & ~clr;
   assign readDone  = busyDone & ~opSeek;

   // Media on-line edges
   assign molChg  = mol ^ lastMol;
   assign molRise = mol & ~lastMol;

   assign ataSet = busyDone | molChg | refuseIlf | refuseRmr | refuseUns | (cmd.go & err);

   // Busy timer
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busyCnt <= '0;
         opSeek  <= 1'b0;
         lastMol <= 1'b0;
      end
      else
      begin
         lastMol <= mol;
         if (clr)
         begin
            busyCnt <= '0;
            opSeek  <= 1'b0;
         end
         else if (accept & cmd.seek)
         begin
            busyCnt <= CNT_W'(SEEK_TIME);
            opSeek  <= 1'b1;
         end
         else if (accept & cmd.read)
         begin
            busyCnt <= CNT_W'(XFER_TIME);
            opSeek  <= 1'b0;
         end
         else if (busy)
         begin
            busyCnt <= busyCnt - CNT_W'(1);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Status and error state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         er1Reg <= '0;
         ataReg <= 1'b0;
         lstReg <= 1'b0;
         vvReg  <= 1'b0;
         daReg  <= '0;
      end
      else
      begin
         // ER1 sets per refusal cause
         if (clr | (accept & cmd.drvClr))
            er1Reg <= '0;
         else
         begin
            if (refuseIlf) er1Reg[rpPkg::ER1_ILF] <= 1'b1;
            if (refuseRmr) er1Reg[rpPkg::ER1_RMR] <= 1'b1;
            if (refuseUns) er1Reg[rpPkg::ER1_UNS] <= 1'b1;
         end
         // Set beats AS clear so a completion is never lost
         if (clr | (accept & cmd.drvClr))
            ataReg <= 1'b0;
         else if (ataSet)
            ataReg <= 1'b1;
         else if (ataClr)
            ataReg <= 1'b0;
         if (clr | cmd.daWrite)
            lstReg <= 1'b0;
         else if (readDone & (daReg.sector == rpPkg::RP_LAST_SECTOR))
            lstReg <= 1'b1;
         // VV lost on a fresh pack
         if (molRise)
            vvReg <= 1'b0;
         else if (accept & (cmd.preset | cmd.pakAck) & ~err)
            vvReg <= 1'b1;
         // Host write wins over sector advance
         if (cmd.daWrite)
            daReg <= cmd.daValue;
         else if (readDone)
            daReg.sector <= (daReg.sector == rpPkg::RP_LAST_SECTOR) ? 8'd0 :
                            daReg.sector + 8'd1;
      end
   end

   // Status word assembly, low six bits read zero
   always_comb
   begin
      ds                = '0;
      ds[rpPkg::DS_ATA] = ataReg;
      ds[rpPkg::DS_ERR] = err;
      ds[rpPkg::DS_PIP] = busy & opSeek;
      ds[rpPkg::DS_MOL] = mol;
      ds[rpPkg::DS_WRL] = wrl;
      ds[rpPkg::DS_LST] = lstReg;
      ds[rpPkg::DS_PGM] = 1'b0;
      ds[rpPkg::DS_DPR] = dpr;
      ds[rpPkg::DS_DRY] = ~busy;
      ds[rpPkg::DS_VV]  = vvReg;
   end

   assign er1 = er1Reg;
   assign da  = daReg;

endmodule

`default_nettype wire

//--- verilog/rpReadMux.sv
// Register read port
// Picks the addressed drive register and builds the attention summary

`default_nettype none

module rpReadMux #(
   parameter int NUM_DRIVES = 4
)
(
   input  logic [2:0]                      regAddr,
   input  logic [1:0]                      drvSel,
   input  rpPkg::rpCmd_t [NUM_DRIVES-1:0]  cmdAll,
   input  logic [NUM_DRIVES-1:0][15:0]     dsAll,
   input  logic [NUM_DRIVES-1:0][15:0]     er1All,
   input  logic [NUM_DRIVES-1:0][15:0]     daAll,
   output logic [15:0]                     rdData
);

   logic [15:0]       asWord;
   rpPkg::rpCsWord_t  csView;

   ////////////////////////////////////////////////////////////
   // Read selection
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      // One ATA bit per drive, drive 0 at bit 0
      asWord = '0;
      for (int i = 0; i < NUM_DRIVES; i++)
      begin
         asWord[i] = dsAll[i][rpPkg::DS_ATA];
      end
      csView = '0;
      rdData = '0;
      if (regAddr == rpPkg::RP_ADDR_AS)
         rdData = asWord;
      else if (int'(drvSel) < NUM_DRIVES)
      begin
         case (regAddr)
            rpPkg::RP_ADDR_CS1:
            begin
               // Last written function, GO reads zero
               csView.fn = cmdAll[drvSel].lastFn;
               rdData    = csView;
            end
            rpPkg::RP_ADDR_DS:  rdData = dsAll[drvSel];
            rpPkg::RP_ADDR_ER1: rdData = er1All[drvSel];
            rpPkg::RP_ADDR_DA:  rdData = daAll[drvSel];
            // Unmapped addresses read zero
            default:            rdData = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/rpDiskCtrl.sv
// Disk controller register subsystem top
// Write decoder, array of drives and read port

`default_nettype none

module rpDiskCtrl #(
   parameter int NUM_DRIVES = 4,
   parameter int SEEK_TIME  = 12,
   parameter int XFER_TIME  = 6
)
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   regWrite,
   input  logic [2:0]             regAddr,
   input  logic [1:0]             drvSel,
   input  rpPkg::rpWriteWord_t    wrData,
   input  logic                   clr,
   input  logic [NUM_DRIVES-1:0]  mol,
   input  logic [NUM_DRIVES-1:0]  wrl,
   input  logic [NUM_DRIVES-1:0]  dpr,
   output logic [15:0]            rdData
);

   rpPkg::rpCmd_t [NUM_DRIVES-1:0] cmd;
   logic [NUM_DRIVES-1:0]          ataClr;
   logic [NUM_DRIVES-1:0][15:0]    dsAll;
   logic [NUM_DRIVES-1:0][15:0]    er1All;
   logic [NUM_DRIVES-1:0][15:0]    daAll;

   // Write path
   rpCmdDecode #(.NUM_DRIVES(NUM_DRIVES)) cmdDecode0 (
      .clk(clk), .rst(rst), .regWrite(regWrite), .regAddr(regAddr),
      .drvSel(drvSel), .wrData(wrData), .cmd(cmd), .ataClr(ataClr)
   );

   // One unit per drive, busyDone left for the bound checks
   for (genvar i = 0; i < NUM_DRIVES; i++)
   begin : gDrive
      rpDrive #(.SEEK_TIME(SEEK_TIME), .XFER_TIME(XFER_TIME)) drive0 (
         .clk(clk), .rst(rst), .clr(clr), .cmd(cmd[i]), .ataClr(ataClr[i]),
         .mol(mol[i]), .wrl(wrl[i]), .dpr(dpr[i]),
         .ds(dsAll[i]), .er1(er1All[i]), .da(daAll[i]), .busyDone()
      );
   end

   // Read path
   rpReadMux #(.NUM_DRIVES(NUM_DRIVES)) readMux0 (
      .regAddr(regAddr), .drvSel(drvSel), .cmdAll(cmd),
      .dsAll(dsAll), .er1All(er1All), .daAll(daAll), .rdData(rdData)
   );

endmodule

`default_nettype wire

//--- bench/rpDrive_asserts.sv
// Drive checks bound into every rpDrive
// Timer, completion and controller clear rules

`default_nettype none

module rpDriveAsserts (
   input logic        clk,
   input logic        rst,
   input logic        clr,
   input logic [15:0] ds,
   input logic [15:0] er1,
   input logic        busyDone
);

   // Operation in progress keeps DRY low and PIP steady until it completes
   busyHolds: assert property (@(posedge clk) disable iff (rst)
      (!ds[rpPkg::DS_DRY] && !busyDone && !clr)
      |=> (!ds[rpPkg::DS_DRY] && $stable(ds[rpPkg::DS_PIP])))
      else $error("Operation ended early or PIP changed while busy");

   // Completion returns DRY and raises attention on the next edge
   doneSetsAta: assert property (@(posedge clk) disable iff (rst)
      busyDone |=> (ds[rpPkg::DS_ATA] && ds[rpPkg::DS_DRY]))
      else $error("ATA or DRY not set after busyDone");

   // Controller clear empties ER1 and aborts the timer
   clrEmptiesEr1: assert property (@(posedge clk) disable iff (rst)
      clr |=> ((er1 == 16'd0) && ds[rpPkg::DS_DRY]))
      else $error("ER1 not zero or drive still busy after clr");

endmodule

bind rpDrive rpDriveAsserts asserts0 (
   .clk(clk), .rst(rst), .clr(clr), .ds(ds), .er1(er1), .busyDone(busyDone)
);

`default_nettype wire

//--- bench/rpTb.sv
// Disk controller testbench
// Random host operations checked against a cycle model of every drive

`default_nettype none

module rpTb;

   localparam int NUM_DRIVES = 4;
   localparam int SEEK_TIME  = 12;
   localparam int XFER_TIME  = 6;
   localparam int RST_CYCLES = 8;
   localparam int NUM_OPS    = 400;
   // Worst op is issue, seek wait and full readback
   localparam int OP_CYCLES  = SEEK_TIME + 4 + 4 * NUM_DRIVES + 3;
   localparam int WATCHDOG   = (RST_CYCLES + NUM_OPS * OP_CYCLES) * 10;

   logic                   clk;
   logic                   rst;
   logic                   regWrite;
   logic [2:0]             regAddr;
   logic [1:0]             drvSel;
   rpPkg::rpWriteWord_t    wrData;
   logic                   clr;
   logic [NUM_DRIVES-1:0]  mol;
   logic [NUM_DRIVES-1:0]  wrl;
   logic [NUM_DRIVES-1:0]  dpr;
   logic [15:0]            rdData;

   int          seed;
   int          errors;
   int          checks;
   int          waitN;
   logic [31:0] rnd;
   logic [3:0]  kind;
   logic [1:0]  sel;
   logic [4:0]  fn;
   logic        poke;

   // Drive state in the model
   logic [NUM_DRIVES-1:0] mAta, mLst, mVv, mOpSeek, mLastMol;
   logic [15:0]           mEr1 [NUM_DRIVES];
   logic [15:0]           mDa [NUM_DRIVES];
   int                    mCnt [NUM_DRIVES];
   logic [4:0]            mFn [NUM_DRIVES];
   // Decoder stage one cycle ahead of the drives
   logic [NUM_DRIVES-1:0] pGo, pDaW, pAtaClr;
   logic [4:0]            pFn [NUM_DRIVES];
   logic [15:0]           pDaV [NUM_DRIVES];

   rpDiskCtrl dut0 (
      .clk(clk), .rst(rst), .regWrite(regWrite), .regAddr(regAddr), .drvSel(drvSel),
      .wrData(wrData), .clr(clr), .mol(mol), .wrl(wrl), .dpr(dpr), .rdData(rdData)
   );

   always #5 clk = ~clk;

   initial
   begin
      #(WATCHDOG);
      $display("Timeout, the run did not finish in time");
      $display("Test FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic logic isLegalFn(input logic [4:0] code);
      return (code == rpPkg::FN_NOP) || (code == rpPkg::FN_SEEK) ||
             (code == rpPkg::FN_DRVCLR) || (code == rpPkg::FN_PRESET) ||
             (code == rpPkg::FN_PAKACK) || (code == rpPkg::FN_READ);
   endfunction

   function automatic logic [15:0] expectedDs(input logic [1:0] d);
      logic [15:0] w;
      w = '0;
      w[rpPkg::DS_ATA] = mAta[d];
      w[rpPkg::DS_ERR] = (mEr1[d] != 16'd0);
      w[rpPkg::DS_PIP] = (mCnt[d] != 0) && mOpSeek[d];
      w[rpPkg::DS_MOL] = mol[d];
      w[rpPkg::DS_WRL] = wrl[d];
      w[rpPkg::DS_LST] = mLst[d];
      w[rpPkg::DS_DPR] = dpr[d];
      w[rpPkg::DS_DRY] = (mCnt[d] == 0);
      w[rpPkg::DS_VV]  = mVv[d];
      return w;
   endfunction

   // One clock edge of the whole subsystem
   task automatic modelEdge;
      logic busy, err, ill, rmr, uns, acc, done, isSeek, isRead, isDrvClr;
      if (rst)
      begin
         {mAta, mLst, mVv, mOpSeek, mLastMol, pGo, pDaW, pAtaClr} = '0;
         for (int d = 0; d < NUM_DRIVES; d++)
         begin
            mEr1[d] = '0;
            mDa[d]  = '0;
            mCnt[d] = 0;
            mFn[d]  = '0;
            pFn[d]  = '0;
            pDaV[d] = '0;
         end
      end
      else
      begin
         for (int d = 0; d < NUM_DRIVES; d++)
         begin
            busy     = (mCnt[d] != 0);
            err      = (mEr1[d] != 16'd0);
            isSeek   = (pFn[d] == rpPkg::FN_SEEK);
            isRead   = (pFn[d] == rpPkg::FN_READ);
            isDrvClr = (pFn[d] == rpPkg::FN_DRVCLR);
            ill      = pGo[d] && !isLegalFn(pFn[d]);
            rmr      = pGo[d] && !ill && busy;
            uns      = pGo[d] && !ill && !busy && (isSeek || isRead) && !mol[d];
            acc      = pGo[d] && !ill && !rmr && !uns;
            done     = (mCnt[d] == 1) && !clr;
            // Attention set wins over an AS clear
            if (clr || (acc && isDrvClr))
               mAta[d] = 1'b0;
            else if (done || (mol[d] != mLastMol[d]) || ill || rmr || uns || (pGo[d] && err))
               mAta[d] = 1'b1;
            else if (pAtaClr[d])
               mAta[d] = 1'b0;
            // Volume valid
            if (mol[d] && !mLastMol[d])
               mVv[d] = 1'b0;
            else if (acc && !err &&
                     (pFn[d] == rpPkg::FN_PRESET || pFn[d] == rpPkg::FN_PAKACK))
               mVv[d] = 1'b1;
            if (clr || (acc && isDrvClr))
               mEr1[d] = '0;
            else
            begin
               if (ill)
                  mEr1[d][rpPkg::ER1_ILF] = 1'b1;
               if (rmr)
                  mEr1[d][rpPkg::ER1_RMR] = 1'b1;
               if (uns)
                  mEr1[d][rpPkg::ER1_UNS] = 1'b1;
            end
            // Last sector flag then sector advance
            if (clr || pDaW[d])
               mLst[d] = 1'b0;
            else if (done && !mOpSeek[d] && mDa[d][7:0] == rpPkg::RP_LAST_SECTOR)
               mLst[d] = 1'b1;
            if (pDaW[d])
               mDa[d] = pDaV[d];
            else if (done && !mOpSeek[d])
               mDa[d][7:0] = (mDa[d][7:0] == rpPkg::RP_LAST_SECTOR) ? 8'd0 : mDa[d][7:0] + 8'd1;
            // Busy timer
            if (clr)
            begin
               mCnt[d]    = 0;
               mOpSeek[d] = 1'b0;
            end
            else if (acc && isSeek)
            begin
               mCnt[d]    = SEEK_TIME;
               mOpSeek[d] = 1'b1;
            end
            else if (acc && isRead)
            begin
               mCnt[d]    = XFER_TIME;
               mOpSeek[d] = 1'b0;
            end
            else if (busy)
               mCnt[d] = mCnt[d] - 1;
            mLastMol[d] = mol[d];
         end
         // Decoder stage takes this edge's host write
         {pGo, pDaW, pAtaClr} = '0;
         if (regWrite && regAddr == rpPkg::RP_ADDR_CS1)
         begin
            mFn[drvSel] = wrData.cs.fn;
            pFn[drvSel] = wrData.cs.fn;
            pGo[drvSel] = wrData.cs.go;
         end
         if (regWrite && regAddr == rpPkg::RP_ADDR_DA)
         begin
            pDaW[drvSel] = 1'b1;
            pDaV[drvSel] = wrData;
         end
         if (regWrite && regAddr == rpPkg::RP_ADDR_AS)
            pAtaClr = wrData[NUM_DRIVES-1:0];
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Clocking, checks and readback
   ////////////////////////////////////////////////////////////

   // Model follows the edge and inputs change just after it
   task automatic tick;
      @(posedge clk);
      modelEdge();
      #1;
   endtask

   task automatic check(input string name, input logic [15:0] expected,
                        input logic [15:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   task automatic readCheck(input logic [2:0] addr, input logic [1:0] d);
      logic [15:0] expected;
      string       nm;
      regAddr = addr;
      drvSel  = d;
      case (addr)
         rpPkg::RP_ADDR_CS1:
         begin
            expected = {10'd0, mFn[d], 1'b0};
            nm       = "cs1";
         end
         rpPkg::RP_ADDR_DS:
         begin
            expected = expectedDs(d);
            nm       = "ds";
         end
         rpPkg::RP_ADDR_ER1:
         begin
            expected = mEr1[d];
            nm       = "er1";
         end
         rpPkg::RP_ADDR_DA:
         begin
            expected = mDa[d];
            nm       = "da";
         end
         default:
         begin
            expected = 16'(mAta);
            nm       = "as";
         end
      endcase
      #1;
      check($sformatf("%s[%0d]", nm, d), expected, rdData);
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      seed     = 32'h12f5;
      errors   = 0;
      checks   = 0;
      clk      = 1'b0;
      rst      = 1'b1;
      regWrite = 1'b0;
      regAddr  = '0;
      drvSel   = '0;
      wrData   = '0;
      clr      = 1'b0;
      mol      = '1;
      wrl      = '0;
      dpr      = '0;
      repeat (RST_CYCLES) tick();
      rst = 1'b0;
      for (int n = 0; n < NUM_OPS; n++)
      begin
         tick();
         rnd    = $random(seed);
         kind   = rnd[3:0];
         sel    = rnd[5:4];
         drvSel = sel;
         waitN  = 2;
         poke   = 1'b0;
         if (kind < 4'd8)
         begin
            // Mostly legal functions with one slot for any code
            case (rnd[8:6])
               3'd0: fn = rpPkg::FN_NOP;
               3'd1: fn = rpPkg::FN_SEEK;
               3'd2: fn = rpPkg::FN_DRVCLR;
               3'd3: fn = rpPkg::FN_PRESET;
               3'd4: fn = rpPkg::FN_PAKACK;
               3'd7: fn = rnd[20:16];
               default: fn = rpPkg::FN_READ;
            endcase
            regWrite       = 1'b1;
            regAddr        = rpPkg::RP_ADDR_CS1;
            wrData.cs.rsvd = rnd[31:22];
            wrData.cs.fn   = fn;
            wrData.cs.go   = (rnd[11:9] != 3'd0);
            if (fn == rpPkg::FN_SEEK)
               waitN = waitN + SEEK_TIME;
            if (fn == rpPkg::FN_READ)
               waitN = waitN + XFER_TIME;
            poke = rnd[12] && (waitN > 2);
         end
         else if (kind < 4'd11)
         begin
            // Sectors around the end of the track
            regWrite         = 1'b1;
            regAddr          = rpPkg::RP_ADDR_DA;
            wrData.da.track  = rnd[23:16];
            wrData.da.sector = 8'd18 + {5'd0, rnd[8:6]};
         end
         else if (kind < 4'd13)
         begin
            regWrite = 1'b1;
            regAddr  = rpPkg::RP_ADDR_AS;
            wrData   = rnd[31:16];
         end
         else if (kind == 4'd13)
            clr = 1'b1;
         else if (kind == 4'd14)
            mol[sel] = ~mol[sel];
         else
         begin
            wrl = rnd[19:16];
            dpr = rnd[23:20];
         end
         // DS of the target drive every cycle while it works
         for (int j = 0; j < waitN; j++)
         begin
            tick();
            regWrite = 1'b0;
            clr      = 1'b0;
            if (poke && j == 3)
            begin
               // Second command is normally refused as busy
               regWrite     = 1'b1;
               regAddr      = rpPkg::RP_ADDR_CS1;
               drvSel       = sel;
               wrData.cs.fn = rnd[28:24];
               wrData.cs.go = 1'b1;
            end
            else
               readCheck(rpPkg::RP_ADDR_DS, sel);
         end
         for (int d = 0; d < NUM_DRIVES; d++)
         begin
            tick();
            readCheck(rpPkg::RP_ADDR_DS, 2'(d));
            tick();
            readCheck(rpPkg::RP_ADDR_ER1, 2'(d));
            tick();
            readCheck(rpPkg::RP_ADDR_DA, 2'(d));
            tick();
            readCheck(rpPkg::RP_ADDR_CS1, 2'(d));
         end
         tick();
         readCheck(rpPkg::RP_ADDR_AS, 2'd0);
      end
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
verilog/rpPkg.sv
verilog/rpCmdDecode.sv
verilog/rpDrive.sv
verilog/rpReadMux.sv
verilog/rpDiskCtrl.sv
bench/rpDrive_asserts.sv
bench/rpTb.sv

//--- Makefile
# Verilator build and run of the disk controller testbench

sim:
	verilator --binary --timing --assert -j 0 --top-module rpTb -f files.f
	./obj_dir/VrpTb > sim.log 2>&1 || echo "Test FAILED" >> sim.log
	cat sim.log
	! grep -q "Test FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
